/* source/vec_pkg.sv */
package vec_pkg;

    // float16 geometry
    localparam int fp_width  = 16;
    localparam int exp_width = 5;
    localparam int man_width = 10;
    localparam int exp_bias  = 15;
    localparam logic [exp_width-1:0] exp_max = '1;   // all ones, infinity

    localparam int lanes   = 3;   // x, y, z
    localparam int latency = 5;   // valid_in edge to valid_out, every opcode

    typedef logic [fp_width-1:0] float16;   // sign, exponent, mantissa
    typedef float16 [lanes-1:0] vec3;        // lane 0 is x

    // opcodes seen at the top level
    typedef enum logic [1:0] {
        op_mul  = 2'd0,   // elementwise product, also scale
        op_add  = 2'd1,   // translation
        op_dot  = 2'd2,   // a.b
        op_dot2 = 2'd3    // 2*(a.b)
    } vec_op_e;

    typedef enum logic {
        lane_mul = 1'b0,
        lane_add = 1'b1
    } lane_op_e;

    // what the result stage does with the lanes
    typedef enum logic [1:0] {
        red_none       = 2'd0,
        red_sum        = 2'd1,
        red_sum_double = 2'd2
    } reduce_e;

endpackage

/* source/fp16_mul.sv */
`timescale 1ns/1ps

module fp16_mul (
    input  vec_pkg::float16 x,
    input  vec_pkg::float16 y,
    output vec_pkg::float16 p
);
    import vec_pkg::*;

    logic                 sign;     // xor of input signs
    logic [exp_width-1:0] ex;
    logic [exp_width-1:0] ey;
    logic                 x_zero;   // zero or subnormal
    logic                 y_zero;
    logic                 x_inf;
    logic                 y_inf;
    logic [21:0]          prod;     // 11 x 11 significands
    logic                 norm;     // product landed in [2,4)
    logic [man_width-1:0] frac;
    logic [6:0]           e_sum;    // carries the bias twice
    logic [6:0]           e_res;

    assign sign   = x[fp_width-1] ^ y[fp_width-1];
    assign ex     = x[man_width +: exp_width];
    assign ey     = y[man_width +: exp_width];
    assign x_zero = (ex == '0);       // subnormals read as zero
    assign y_zero = (ey == '0);
    assign x_inf  = (ex == exp_max);
    assign y_inf  = (ey == exp_max);

    assign prod  = {1'b1, x[man_width-1:0]} * {1'b1, y[man_width-1:0]};
    assign norm  = prod[21];
    assign frac  = norm ? prod[20:11] : prod[19:10];   // low bits dropped, truncation
    assign e_sum = ex + ey + norm;
    assign e_res = e_sum - 7'(exp_bias);

    always_comb begin
        if (x_inf || y_inf) begin
            p = {sign, exp_max, {man_width{1'b0}}};   // no nan, inf wins
        end else if (x_zero || y_zero || (e_sum <= exp_bias)) begin
            p = {sign, {(fp_width-1){1'b0}}};         // signed zero, covers underflow
        end else if (e_sum >= (exp_bias + exp_max)) begin
            p = {sign, exp_max, {man_width{1'b0}}};   // overflow to inf
        end else begin
            p = {sign, e_res[exp_width-1:0], frac};
        end
    end

endmodule

/* source/fp16_add.sv */
`timescale 1ns/1ps

module fp16_add (
    input  vec_pkg::float16 x,
    input  vec_pkg::float16 y,
    output vec_pkg::float16 s
);
    import vec_pkg::*;

    logic [exp_width-1:0] ex;
    logic [exp_width-1:0] ey;
    logic [man_width-1:0] mx;         // mantissa, zeroed for subnormals
    logic [man_width-1:0] my;
    logic                 swap;       // y has the larger magnitude
    logic                 s_big;
    logic                 s_small;
    logic [exp_width-1:0] e_big;
    logic [exp_width-1:0] e_small;
    logic [13:0]          sig_big;    // hidden, mantissa, 3 guard bits
    logic [13:0]          sig_small;
    logic [exp_width-1:0] shift;
    logic [44:0]          sm_wide;    // room for any shift up to 30
    logic [13:0]          sig_al;     // aligned, sticky in lsb
    logic                 sub;
    logic [14:0]          sum;        // one carry bit on top
    logic [3:0]           lz;
    logic [14:0]          norm;
    logic [5:0]           e_top;
    logic [5:0]           e_res;

    assign ex = x[man_width +: exp_width];
    assign ey = y[man_width +: exp_width];
    assign mx = (ex == '0) ? '0 : x[man_width-1:0];   // flush subnormal
    assign my = (ey == '0) ? '0 : y[man_width-1:0];

    // order by magnitude so the subtract never goes negative
    assign swap    = {ey, my} > {ex, mx};
    assign s_big   = swap ? y[fp_width-1] : x[fp_width-1];
    assign s_small = swap ? x[fp_width-1] : y[fp_width-1];
    assign e_big   = swap ? ey : ex;
    assign e_small = swap ? ex : ey;
    assign sig_big   = swap ? {(ey != '0), my, 3'b000} : {(ex != '0), mx, 3'b000};
    assign sig_small = swap ? {(ex != '0), mx, 3'b000} : {(ey != '0), my, 3'b000};

    // align the smaller one, keep what falls off as a sticky bit
    assign shift   = e_big - e_small;
    assign sm_wide = {sig_small, 31'b0} >> shift;
    assign sig_al  = sm_wide[44:31] | {13'b0, |sm_wide[30:0]};

    assign sub = s_big ^ s_small;
    assign sum = sub ? ({1'b0, sig_big} - {1'b0, sig_al})
                     : ({1'b0, sig_big} + {1'b0, sig_al});

    // leading zero count, highest set bit wins
    always_comb begin
        lz = 4'd15;
        for (int i = 0; i < 15; i++) begin
            if (sum[i]) lz = 4'(14 - i);
        end
    end

    assign norm  = sum << lz;               // hidden bit to bit 14
    assign e_top = {1'b0, e_big} + 6'd1;    // +1 for the carry slot
    assign e_res = e_top - {2'b0, lz};

    always_comb begin
        if ((ex == exp_max) || (ey == exp_max)) begin
            s = {s_big, exp_max, {man_width{1'b0}}};       // inf is always the big one
        end else if (sum == '0) begin
            s = {s_big & s_small, {(fp_width-1){1'b0}}};   // cancel gives +0, -0 + -0 stays -0
        end else if (e_top <= {2'b0, lz}) begin
            s = {s_big, {(fp_width-1){1'b0}}};             // underflow, keep sign
        end else if (e_res >= {1'b0, exp_max}) begin
            s = {s_big, exp_max, {man_width{1'b0}}};       // overflow
        end else begin
            s = {s_big, e_res[exp_width-1:0], norm[13:4]}; // guard bits dropped
        end
    end

endmodule

/* source/vec_decode.sv */
`timescale 1ns/1ps

module vec_decode (
    input  logic              clk,
    input  logic              rst,
    input  logic              valid_in,
    input  vec_pkg::vec_op_e  op,
    input  vec_pkg::vec3      a,
    input  vec_pkg::vec3      b,
    output logic              dec_valid,
    output vec_pkg::lane_op_e dec_lane_op,
    output vec_pkg::reduce_e  dec_reduce,
    output vec_pkg::vec3      dec_a,
    output vec_pkg::vec3      dec_b
);
    import vec_pkg::*;

    lane_op_e lane_op_nx;
    reduce_e  reduce_nx;

    always_comb begin
        lane_op_nx = lane_mul;    // mul, dot and dot2 all multiply lanes
        reduce_nx  = red_none;
        case (op)
            op_add:  lane_op_nx = lane_add;
            op_dot:  reduce_nx  = red_sum;
            op_dot2: reduce_nx  = red_sum_double;
            default: lane_op_nx = lane_mul;   // op_mul, scale
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid   <= 1'b0;
            dec_lane_op <= lane_mul;
            dec_reduce  <= red_none;
        end else begin
            dec_valid   <= valid_in;
            dec_lane_op <= lane_op_nx;
            dec_reduce  <= reduce_nx;
        end
    end

    always_ff @(posedge clk) begin
        dec_a <= a;   // operands, qualified by dec_valid
        dec_b <= b;
    end

endmodule

/* source/vec_execute.sv */
`timescale 1ns/1ps

module vec_execute (
    input  logic              clk,
    input  logic              rst,
    input  logic              dec_valid,
    input  vec_pkg::lane_op_e dec_lane_op,
    input  vec_pkg::reduce_e  dec_reduce,
    input  vec_pkg::vec3      dec_a,
    input  vec_pkg::vec3      dec_b,
    output logic              ex_valid,
    output vec_pkg::reduce_e  ex_reduce,
    output vec_pkg::vec3      ex_lanes
);
    import vec_pkg::*;

    vec3 prod;       // per lane a*b
    vec3 sum;        // per lane a+b
    vec3 lane_res;   // chosen by lane op

    for (genvar i = 0; i < lanes; i++) begin : g_lane
        fp16_mul u_mul (
            .x (dec_a[i]),
            .y (dec_b[i]),
            .p (prod[i])
        );
        fp16_add u_add (
            .x (dec_a[i]),
            .y (dec_b[i]),
            .s (sum[i])
        );
        assign lane_res[i] = (dec_lane_op == lane_add) ? sum[i] : prod[i];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid  <= 1'b0;
            ex_reduce <= red_none;
        end else begin
            ex_valid  <= dec_valid;
            ex_reduce <= dec_reduce;   // follows its lanes to result
        end
    end

    always_ff @(posedge clk) begin
        ex_lanes <= lane_res;
    end

endmodule

/* source/vec_result.sv */
`timescale 1ns/1ps

module vec_result (
    input  logic             clk,
    input  logic             rst,
    input  logic             ex_valid,
    input  vec_pkg::reduce_e ex_reduce,
    input  vec_pkg::vec3     ex_lanes,
    output logic             valid_out,
    output vec_pkg::vec3     res,
    output vec_pkg::float16  dot
);
    import vec_pkg::*;

    float16  xy;          // x+y, comb
    float16  xyz;         // (x+y)+z, comb
    float16  dbl;         // sum+sum, comb
    float16  s1_xy;
    vec3     s1_lanes;    // z read from lane 2 here
    reduce_e s1_reduce;
    logic    s1_valid;
    float16  s2_sum;
    vec3     s2_lanes;
    reduce_e s2_reduce;
    logic    s2_valid;

    fp16_add u_add_xy (
        .x (ex_lanes[0]),
        .y (ex_lanes[1]),
        .s (xy)
    );
    fp16_add u_add_z (
        .x (s1_xy),
        .y (s1_lanes[2]),
        .s (xyz)
    );
    fp16_add u_add_dbl (
        .x (s2_sum),
        .y (s2_sum),
        .s (dbl)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            valid_out <= 1'b0;
            s1_reduce <= red_none;
            s2_reduce <= red_none;
        end else begin
            s1_valid  <= ex_valid;
            s2_valid  <= s1_valid;
            valid_out <= s2_valid;   // 3 cycles after ex_valid
            s1_reduce <= ex_reduce;
            s2_reduce <= s1_reduce;
        end
    end

    // data path, lanes ride beside the sum
    always_ff @(posedge clk) begin
        s1_xy    <= xy;
        s1_lanes <= ex_lanes;
        s2_sum   <= xyz;
        s2_lanes <= s1_lanes;
        res      <= s2_lanes;
        dot      <= (s2_reduce == red_sum_double) ? dbl : s2_sum;   // plain sum otherwise
    end

endmodule

/* source/vec_unit.sv */
`timescale 1ns/1ps

module vec_unit (
    input  logic             clk,
    input  logic             rst,
    input  logic             valid_in,
    input  vec_pkg::vec_op_e op,
    input  vec_pkg::vec3     a,
    input  vec_pkg::vec3     b,
    output logic             valid_out,
    output vec_pkg::vec3     res,
    output vec_pkg::float16  dot
);
    import vec_pkg::*;

    // decode to execute
    logic     dec_valid;
    lane_op_e dec_lane_op;
    reduce_e  dec_reduce;
    vec3      dec_a;
    vec3      dec_b;

    // execute to result
    logic     ex_valid;
    reduce_e  ex_reduce;
    vec3      ex_lanes;

    vec_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .valid_in    (valid_in),
        .op          (op),
        .a           (a),
        .b           (b),
        .dec_valid   (dec_valid),
        .dec_lane_op (dec_lane_op),
        .dec_reduce  (dec_reduce),
        .dec_a       (dec_a),
        .dec_b       (dec_b)
    );

    vec_execute u_execute (
        .clk         (clk),
        .rst         (rst),
        .dec_valid   (dec_valid),
        .dec_lane_op (dec_lane_op),
        .dec_reduce  (dec_reduce),
        .dec_a       (dec_a),
        .dec_b       (dec_b),
        .ex_valid    (ex_valid),
        .ex_reduce   (ex_reduce),
        .ex_lanes    (ex_lanes)
    );

    vec_result u_result (
        .clk       (clk),
        .rst       (rst),
        .ex_valid  (ex_valid),
        .ex_reduce (ex_reduce),
        .ex_lanes  (ex_lanes),
        .valid_out (valid_out),
        .res       (res),
        .dot       (dot)
    );

endmodule

/* sim/vec_unit_properties.sv */
`timescale 1ns/1ps

module vec_unit_properties (
    input logic            clk,
    input logic            rst,
    input logic            valid_in,
    input logic            valid_out,
    input vec_pkg::vec3    res,
    input vec_pkg::float16 dot
);
    import vec_pkg::*;

    // fixed depth, every opcode
    a_valid_latency: assert property (@(posedge clk) disable iff (rst)
        valid_in |-> ##latency valid_out)
        else $error("valid_in not followed by valid_out after %0d cycles", latency);

    // no result without a matching request
    a_no_spurious: assert property (@(posedge clk) disable iff (rst)
        valid_out |-> $past(valid_in, latency))
        else $error("valid_out without valid_in %0d cycles earlier", latency);

    a_reset_quiet: assert property (@(posedge clk)
        rst |=> !valid_out ##1 !valid_out)
        else $error("valid_out high during or right after reset");

    a_no_x: assert property (@(posedge clk) disable iff (rst)
        valid_out |-> !$isunknown({res, dot}))
        else $error("res or dot unknown while valid_out is high");

endmodule

bind vec_unit vec_unit_properties u_properties (
    .clk       (clk),
    .rst       (rst),
    .valid_in  (valid_in),
    .valid_out (valid_out),
    .res       (res),
    .dot       (dot)
);

/* sim/vec_unit_tb.sv */
`timescale 1ns/1ps

module vec_unit_tb;
    import vec_pkg::*;

    localparam int    clk_period = 40;
    localparam int    rst_cycles = 16;
    localparam int    max_vecs   = 64;
    localparam int    max_gap    = 3;    // most idle cycles between ops in the gap test
    localparam string data_file  = "sim/vec_unit_input.txt";

    logic    clk;
    logic    rst;
    logic    valid_in;
    vec_op_e op;
    vec3     a;
    vec3     b;
    logic    valid_out;
    vec3     res;
    float16  dot;

    // vectors as read from the data file
    logic [1:0] v_op  [max_vecs];
    vec3        v_a   [max_vecs];
    vec3        v_b   [max_vecs];
    vec3        v_res [max_vecs];
    float16     v_dot [max_vecs];
    int         n_vecs = 0;
    logic       loaded = 1'b0;

    int q_idx   [$];     // outstanding ops with the oldest first
    int q_cycle [$];     // cycle count at issue
    int cycle   = 0;
    int checks  = 0;
    int errors  = 0;
    int tests   = 0;
    int err_mark = 0;    // errors when the current test began
    int out_idx;
    int out_cycle;

    vec_unit uut (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (valid_in),
        .op        (op),
        .a         (a),
        .b         (b),
        .valid_out (valid_out),
        .res       (res),
        .dot       (dot)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period/2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic check_vec(input vec3 got, input vec3 exp, input int idx);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %0t: vector %0d res %h, expected %h", $time, idx, got, exp);
        end
    endtask

    task automatic check_dot(input float16 got, input float16 exp, input int idx);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %0t: vector %0d dot %h, expected %h", $time, idx, got, exp);
        end
    endtask

    // results are sampled mid cycle away from the rising edge
    always @(negedge clk) begin
        if (valid_out === 1'b1) begin
            if (q_idx.size() == 0) begin
                errors++;
                $display("%0t: valid_out high with no operation outstanding", $time);
            end else begin
                out_idx   = q_idx.pop_front();
                out_cycle = q_cycle.pop_front();
                if (cycle != out_cycle + latency) begin
                    errors++;
                    $display("%0t: vector %0d came out after %0d cycles instead of %0d",
                             $time, out_idx, cycle - out_cycle, latency);
                end
                check_vec(res, v_res[out_idx], out_idx);   // lane products for dot ops
                if (v_op[out_idx] == op_dot || v_op[out_idx] == op_dot2) begin
                    check_dot(dot, v_dot[out_idx], out_idx);
                end
            end
        end
    end

    task automatic load_vectors();
        int         fd;
        int         cnt;
        string      line;
        logic [1:0] f_op;
        vec3        f_a;
        vec3        f_b;
        vec3        f_res;
        float16     f_dot;
        fd = $fopen(data_file, "r");
        if (fd == 0) begin
            errors++;
            $display("could not open %s", data_file);
        end else begin
            while (!$feof(fd) && n_vecs < max_vecs) begin
                if ($fgets(line, fd) != 0) begin
                    cnt = $sscanf(line, "%h %h %h %h %h", f_op, f_a, f_b, f_res, f_dot);
                    if (cnt == 5) begin   // comment and blank lines fall through
                        v_op[n_vecs]  = f_op;
                        v_a[n_vecs]   = f_a;
                        v_b[n_vecs]   = f_b;
                        v_res[n_vecs] = f_res;
                        v_dot[n_vecs] = f_dot;
                        n_vecs++;
                    end
                end
            end
            $fclose(fd);
        end
        if (n_vecs == 0) begin
            errors++;
            $display("no test vectors found in %s", data_file);
        end
    endtask

    task automatic issue(input int i, input bit track);
        @(negedge clk);
        valid_in = 1'b1;
        op       = vec_op_e'(v_op[i]);
        a        = v_a[i];
        b        = v_b[i];
        if (track) begin
            q_idx.push_back(i);
            q_cycle.push_back(cycle);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            valid_in = 1'b0;
        end
    endtask

    // wait for every outstanding result up to the pipe depth
    task automatic drain();
        int waited;
        waited = 0;
        idle(1);
        while (q_idx.size() != 0 && waited < latency + 4) begin
            @(negedge clk);
            waited++;
        end
        if (q_idx.size() != 0) begin
            errors++;
            $display("%0t: %0d results never came out", $time, q_idx.size());
            q_idx.delete();
            q_cycle.delete();
        end
    endtask

    task automatic end_test(input string name);
        drain();
        tests++;
        $display("%0t: test %s done, %0d errors", $time, name, errors - err_mark);
        err_mark = errors;
    endtask

    task automatic run_opcode(input vec_op_e sel, input string name);
        for (int i = 0; i < n_vecs; i++) begin
            if (v_op[i] == sel) issue(i, 1'b1);
        end
        end_test(name);
    endtask

    task automatic run_stream(input bit gaps, input string name);
        for (int i = 0; i < n_vecs; i++) begin
            issue(i, 1'b1);
            if (gaps) idle($urandom % (max_gap + 1));
        end
        end_test(name);
    endtask

    // ops in flight when rst rises must vanish and the monitor flags any survivor
    task automatic run_reset();
        for (int i = 0; i < 3 && i < n_vecs; i++) issue(i, 1'b0);
        @(negedge clk);
        valid_in = 1'b0;
        rst      = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        idle(latency + 2);
        for (int i = 0; i < 4 && i < n_vecs; i++) issue(i, 1'b1);   // pipe works again
        end_test("reset");
    endtask

    initial begin
        rst      = 1'b1;
        valid_in = 1'b0;
        op       = op_mul;
        a        = '0;
        b        = '0;
        void'($urandom(88098));
        load_vectors();
        loaded = 1'b1;
        repeat (rst_cycles) @(negedge clk);
        rst = 1'b0;
        run_opcode(op_mul, "mul");
        run_opcode(op_add, "add");
        run_opcode(op_dot, "dot");
        run_opcode(op_dot2, "dot2");
        run_stream(1'b0, "stream");
        run_stream(1'b1, "gaps");
        run_reset();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // three passes over the file with widest gaps and one drain per test
    initial begin
        int limit_cycles;
        wait (loaded === 1'b1);
        limit_cycles = n_vecs * (3 + max_gap) + 8 * (latency + 5) + 40 + rst_cycles;
        #(limit_cycles * clk_period);
        $display("watchdog expired after %0d cycles, tests did not finish", limit_cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* sim/vec_unit_input.txt */
// columns: op a b res dot, all hex; a vector is {z, y, x}
// op 0 mul, 1 add, 2 dot, 3 dot2; dot column unused for ops 0 and 1
0 C20040003E00 BC00B8004000 4200BC004200 0000
0 84003E013C01 38003E013C01 800040813C02 0000
0 4400C8007BFF 340078004000 3C00FC007C00 0000
0 4200C1003E00 400040004000 4600C5004200 0000
0 BE0081000200 BE003C004400 408080000000 0000
1 BE0042003C00 C100BC004000 C40040004200 0000
1 4500C0003C00 C4004000BC00 3C0000000000 0000
1 02004C004C00 3C0084000400 3C004BFF4C00 0000
1 C20001007BFF 3A0002007BFF C08000007C00 0000
1 4600BC003C00 3400BC013C01 4640C0004000 0000
2 420040003C00 460045004400 4C8049004400 5000
2 3800C0003E00 4400C200C000 40004600C200 4500
2 BC0042003E01 3C013E003E01 BC0144804081 45BF
2 00003C007BFF 3C0000003C00 000000007BFF 7BFF
2 C200C000BC00 3C003C003C00 C200C000BC00 C600
3 420040003C00 460045004400 4C8049004400 5400
3 3800C0003E00 4400C200C000 40004600C200 4900
3 BC0042003E01 3C013E003E01 BC0144804081 49BF
3 00003C007BFF 3C0000003C00 000000007BFF 7C00
3 C200C000BC00 3C003C003C00 C200C000BC00 CA00

/* vlog.f */
source/vec_pkg.sv
source/fp16_mul.sv
source/fp16_add.sv
source/vec_decode.sv
source/vec_execute.sv
source/vec_result.sv
source/vec_unit.sv
sim/vec_unit_properties.sv
sim/vec_unit_tb.sv

/* Bender.yml */
package:
  name: vec_unit

sources:
  - files:
      - source/vec_pkg.sv
      - source/fp16_mul.sv
      - source/fp16_add.sv
      - source/vec_decode.sv
      - source/vec_execute.sv
      - source/vec_result.sv
      - source/vec_unit.sv
  - target: simulation
    files:
      - sim/vec_unit_properties.sv
      - sim/vec_unit_tb.sv
